// File: rtl/id_settings.svh
// ----------------------------
// decode stage settings
// data and register file sizes,
// RV32I major opcodes
// ----------------------------

`ifndef ID_SETTINGS_SVH
`define ID_SETTINGS_SVH

`define RV_XLEN        32
`define RV_REG_ADDR_W  5
`define RV_NUM_REGS    32

// major opcodes, instruction bits 6:0
`define RV_OPC_OP      7'b0110011
`define RV_OPC_OP_IMM  7'b0010011
`define RV_OPC_LUI     7'b0110111
`define RV_OPC_AUIPC   7'b0010111
`define RV_OPC_LOAD    7'b0000011

`endif

// File: rtl/id_pkg.sv
// ----------------------------
// decode stage types
// instruction views, ALU ops, result
// zones and the stage bundles
// ----------------------------

`include "id_settings.svh"

package id_pkg;

    // one instruction word, decoded as R, I or U format
    typedef struct packed {
        logic [6:0]                funct7;
        logic [`RV_REG_ADDR_W-1:0] rs2;
        logic [`RV_REG_ADDR_W-1:0] rs1;
        logic [2:0]                funct3;
        logic [`RV_REG_ADDR_W-1:0] rd;
        logic [6:0]                opcode;
    } ins_r_t;

    typedef struct packed {
        logic [11:0]               imm;
        logic [`RV_REG_ADDR_W-1:0] rs1;
        logic [2:0]                funct3;
        logic [`RV_REG_ADDR_W-1:0] rd;
        logic [6:0]                opcode;
    } ins_i_t;

    typedef struct packed {
        logic [19:0]               imm;
        logic [`RV_REG_ADDR_W-1:0] rd;
        logic [6:0]                opcode;
    } ins_u_t;

    typedef union packed {
        ins_r_t r;
        ins_i_t i;
        ins_u_t u;
    } rv_ins_u;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND
    } alu_op_e;

    // where the result is written
    typedef enum logic [1:0] {
        NONE,
        REGF,
        LOADQ
    } zone_e;

    typedef struct packed {
        logic                      uerr;
        logic                      regs1_rd;
        logic [`RV_REG_ADDR_W-1:0] regs1_addr;
        logic                      regs2_rd;
        logic [`RV_REG_ADDR_W-1:0] regs2_addr;
        logic                      regd_tgt;
        logic [`RV_REG_ADDR_W-1:0] regd_addr;
        zone_e                     zone;
        alu_op_e                   alu_op;
        logic [2:0]                funct3;
        logic                      sels1_pc;
        logic                      sels2_imm;
        logic [`RV_XLEN-1:0]       imm;
    } id_ctrl_t;

    typedef struct packed {
        logic                      wr;
        logic [`RV_REG_ADDR_W-1:0] addr;
        logic [`RV_XLEN-1:0]       data;
    } wb_port_t;

    typedef struct packed {
        logic [31:0]               ins;
        alu_op_e                   alu_op;
        logic [2:0]                funct3;
        zone_e                     zone;
        logic [`RV_REG_ADDR_W-1:0] regd_addr;
        logic                      uerr;
    } exs_out_t;

endpackage

// File: rtl/ins_decoder.sv
// ----------------------------
// RV32I subset decoder
// OP, OP-IMM, LUI, AUIPC and loads,
// everything else flagged as uerr
// ----------------------------

`include "id_settings.svh"

module ins_decoder import id_pkg::*; (
    input  rv_ins_u  ins_i,
    output id_ctrl_t ctrl_o
);

    // funct3 plus the alternate bit (funct7 bit 5) to ALU op
    function automatic alu_op_e alu_map(input logic [2:0] funct3, input logic alt);
        alu_op_e op;
        case (funct3)
            3'd0:    op = alt ? SUB : ADD;
            3'd1:    op = SLL;
            3'd2:    op = SLT;
            3'd3:    op = SLTU;
            3'd4:    op = XOR;
            3'd5:    op = alt ? SRA : SRL;
            3'd6:    op = OR;
            default: op = AND;
        endcase
        return op;
    endfunction

    logic [`RV_XLEN-1:0] imm_i;
    logic [`RV_XLEN-1:0] imm_u;
    logic                funct7_ok;
    logic                bad;

    assign imm_i = {{(`RV_XLEN-12){ins_i.i.imm[11]}}, ins_i.i.imm};
    assign imm_u = {ins_i.u.imm, 12'b0};

    // only SUB and SRA may set funct7 bit 5
    assign funct7_ok = (ins_i.r.funct7 == 7'h00) ||
                       (ins_i.r.funct7 == 7'h20 &&
                        (ins_i.r.funct3 == 3'd0 || ins_i.r.funct3 == 3'd5));

    always_comb begin
        ctrl_o            = '0;
        bad               = 1'b0;
        ctrl_o.regs1_addr = ins_i.r.rs1;
        ctrl_o.regs2_addr = ins_i.r.rs2;
        ctrl_o.regd_addr  = ins_i.r.rd;
        ctrl_o.funct3     = ins_i.r.funct3;
        ctrl_o.alu_op     = ADD;
        ctrl_o.zone       = NONE;

        case (ins_i.r.opcode)
            `RV_OPC_OP: begin
                ctrl_o.regs1_rd = 1'b1;
                ctrl_o.regs2_rd = 1'b1;
                ctrl_o.regd_tgt = 1'b1;
                ctrl_o.zone     = REGF;
                ctrl_o.alu_op   = alu_map(ins_i.r.funct3, ins_i.r.funct7[5]);
                bad             = ~funct7_ok;
            end
            `RV_OPC_OP_IMM: begin
                ctrl_o.regs1_rd  = 1'b1;
                ctrl_o.regd_tgt  = 1'b1;
                ctrl_o.zone      = REGF;
                ctrl_o.sels2_imm = 1'b1;
                ctrl_o.imm       = imm_i;
                // upper imm bits are funct7 only for the shifts
                if (ins_i.i.funct3 == 3'd1 || ins_i.i.funct3 == 3'd5) begin
                    ctrl_o.alu_op = alu_map(ins_i.r.funct3, ins_i.r.funct7[5]);
                    bad           = ~funct7_ok;
                end else begin
                    ctrl_o.alu_op = alu_map(ins_i.r.funct3, 1'b0);
                end
            end
            `RV_OPC_LUI: begin
                // x0 + imm
                ctrl_o.regs1_rd   = 1'b1;
                ctrl_o.regs1_addr = '0;
                ctrl_o.regd_tgt   = 1'b1;
                ctrl_o.zone       = REGF;
                ctrl_o.sels2_imm  = 1'b1;
                ctrl_o.imm        = imm_u;
            end
            `RV_OPC_AUIPC: begin
                ctrl_o.regd_tgt  = 1'b1;
                ctrl_o.zone      = REGF;
                ctrl_o.sels1_pc  = 1'b1;
                ctrl_o.sels2_imm = 1'b1;
                ctrl_o.imm       = imm_u;
            end
            `RV_OPC_LOAD: begin
                // base + offset goes to the load queue
                ctrl_o.regs1_rd  = 1'b1;
                ctrl_o.regd_tgt  = 1'b1;
                ctrl_o.zone      = LOADQ;
                ctrl_o.sels2_imm = 1'b1;
                ctrl_o.imm       = imm_i;
                bad              = (ins_i.i.funct3 == 3'd3) || (ins_i.i.funct3 >= 3'd6);
            end
            default: begin
                bad = 1'b1;
            end
        endcase

        if (bad) begin
            ctrl_o.uerr     = 1'b1;
            ctrl_o.regd_tgt = 1'b0;
            ctrl_o.regs1_rd = 1'b0;
            ctrl_o.regs2_rd = 1'b0;
            ctrl_o.zone     = NONE;
        end
    end

endmodule

// File: rtl/load_scoreboard.sv
// ----------------------------
// pending-load scoreboard
// one bit per register with a load
// in flight, holds back decode
// ----------------------------

`include "id_settings.svh"

module load_scoreboard import id_pkg::*; (
    input  logic                      clk_i,
    input  logic                      reset_i,
    input  id_ctrl_t                  ctrl_i,
    input  logic                      pfu_dav_i,
    input  logic                      accept_i,
    input  wb_port_t                  lsq_wb_i,
    input  wb_port_t                  lsq_fwd_i,
    input  logic                      cncl_i,
    input  logic [`RV_REG_ADDR_W-1:0] cncl_addr_i,
    output logic                      ids_stall_o
);

    // load data on the live port or in the forwarding register
    function automatic logic lsq_has(input wb_port_t live, input wb_port_t held,
                                     input logic [`RV_REG_ADDR_W-1:0] addr);
        return (live.wr && live.addr == addr) || (held.wr && held.addr == addr);
    endfunction

    logic [`RV_NUM_REGS-1:1] pending_q;
    logic [`RV_NUM_REGS-1:0] pending;
    logic                    s1_blocked;
    logic                    s2_blocked;
    logic                    rd_blocked;

    // x0 never pending
    assign pending = {pending_q, 1'b0};

    assign s1_blocked = ctrl_i.regs1_rd && pending[ctrl_i.regs1_addr] &&
                        !lsq_has(lsq_wb_i, lsq_fwd_i, ctrl_i.regs1_addr);
    assign s2_blocked = ctrl_i.regs2_rd && pending[ctrl_i.regs2_addr] &&
                        !lsq_has(lsq_wb_i, lsq_fwd_i, ctrl_i.regs2_addr);
    assign rd_blocked = ctrl_i.regd_tgt && pending[ctrl_i.regd_addr];

    assign ids_stall_o = pfu_dav_i && (s1_blocked || s2_blocked || rd_blocked);

    // set on accepted load, clear on load return or cancel
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pending_q <= '0;
        end else begin
            if (accept_i && ctrl_i.zone == LOADQ && ctrl_i.regd_addr != '0) begin
                pending_q[ctrl_i.regd_addr] <= 1'b1;
            end
            if (cncl_i && cncl_addr_i != '0) begin
                pending_q[cncl_addr_i] <= 1'b0;
            end
            if (lsq_wb_i.wr && lsq_wb_i.addr != '0) begin
                pending_q[lsq_wb_i.addr] <= 1'b0;
            end
        end
    end

endmodule

// File: rtl/int_regs.sv
// ----------------------------
// integer register file
// 32 entries, two write ports,
// two registered read ports
// ----------------------------

`include "id_settings.svh"

module int_regs import id_pkg::*; (
    input  logic                      clk_i,
    input  logic                      reset_i,
    input  wb_port_t                  wa_i,
    input  wb_port_t                  wb_i,
    input  logic                      rd_en_i,
    input  logic [`RV_REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [`RV_REG_ADDR_W-1:0] rs2_addr_i,
    output logic [`RV_XLEN-1:0]       rs1_data_o,
    output logic [`RV_XLEN-1:0]       rs2_data_o
);

    logic [`RV_XLEN-1:0]       regs_q [`RV_NUM_REGS];
    logic [`RV_REG_ADDR_W-1:0] rd_addr [2];
    logic [`RV_REG_ADDR_W-1:0] rd_addr_q [2];
    logic [`RV_XLEN-1:0]       rd_data_q [2];

    // port b written last so it wins on the same address
    always_ff @(posedge clk_i) begin
        if (wa_i.wr && wa_i.addr != '0) begin
            regs_q[wa_i.addr] <= wa_i.data;
        end
        if (wb_i.wr && wb_i.addr != '0) begin
            regs_q[wb_i.addr] <= wb_i.data;
        end
    end

    assign rd_addr[0] = rs1_addr_i;
    assign rd_addr[1] = rs2_addr_i;

    for (genvar p = 0; p < 2; p++) begin : g_rd
        always_ff @(posedge clk_i) begin
            if (reset_i) begin
                rd_addr_q[p] <= '0;
                rd_data_q[p] <= '0;
            end else if (rd_en_i) begin
                rd_addr_q[p] <= rd_addr[p];
                // a write on the same edge is already the newest copy
                if (rd_addr[p] == '0) begin
                    rd_data_q[p] <= '0;
                end else if (wb_i.wr && wb_i.addr == rd_addr[p]) begin
                    rd_data_q[p] <= wb_i.data;
                end else if (wa_i.wr && wa_i.addr == rd_addr[p]) begin
                    rd_data_q[p] <= wa_i.data;
                end else begin
                    rd_data_q[p] <= regs_q[rd_addr[p]];
                end
            end else if (rd_addr_q[p] != '0) begin
                // held read follows later writes, so a long stall stays current
                if (wa_i.wr && wa_i.addr == rd_addr_q[p]) begin
                    rd_data_q[p] <= wa_i.data;
                end
                if (wb_i.wr && wb_i.addr == rd_addr_q[p]) begin
                    rd_data_q[p] <= wb_i.data;
                end
            end
        end
    end

    assign rs1_data_o = rd_data_q[0];
    assign rs2_data_o = rd_data_q[1];

endmodule

// File: rtl/operand_fwd.sv
// ----------------------------
// operand forwarding
// write-back forwarding registers,
// newest-copy muxes, operand select
// ----------------------------

`include "id_settings.svh"

module operand_fwd import id_pkg::*; (
    input  logic                      clk_i,
    input  logic                      reset_i,
    input  wb_port_t                  exs_wb_i,
    input  wb_port_t                  lsq_wb_i,
    input  logic [`RV_REG_ADDR_W-1:0] rs1_addr_q_i,
    input  logic [`RV_REG_ADDR_W-1:0] rs2_addr_q_i,
    input  logic [`RV_XLEN-1:0]       rs1_dout_i,
    input  logic [`RV_XLEN-1:0]       rs2_dout_i,
    input  logic [`RV_XLEN-1:0]       pc_q_i,
    input  logic [`RV_XLEN-1:0]       imm_q_i,
    input  logic                      sels1_pc_q_i,
    input  logic                      sels2_imm_q_i,
    output wb_port_t                  lsq_fwd_o,
    output logic [`RV_XLEN-1:0]       regs1_data_o,
    output logic [`RV_XLEN-1:0]       regs2_data_o,
    output logic [`RV_XLEN-1:0]       operand_left_o,
    output logic [`RV_XLEN-1:0]       operand_right_o
);

    // first match wins, x0 straight from the register file
    function automatic logic [`RV_XLEN-1:0] fwd_pick(
        input logic [`RV_REG_ADDR_W-1:0] addr,
        input logic [`RV_XLEN-1:0]       rf_data,
        input wb_port_t                  exs_live,
        input wb_port_t                  exs_held,
        input wb_port_t                  lsq_live,
        input wb_port_t                  lsq_held
    );
        logic [`RV_XLEN-1:0] data;
        if (addr == '0) begin
            data = rf_data;
        end else if (exs_live.wr && exs_live.addr == addr) begin
            data = exs_live.data;
        end else if (exs_held.wr && exs_held.addr == addr) begin
            data = exs_held.data;
        end else if (lsq_live.wr && lsq_live.addr == addr) begin
            data = lsq_live.data;
        end else if (lsq_held.wr && lsq_held.addr == addr) begin
            data = lsq_held.data;
        end else begin
            data = rf_data;
        end
        return data;
    endfunction

    wb_port_t exs_fwd_q;
    wb_port_t lsq_fwd_q;

    // ----------------------------
    // forwarding registers
    // ----------------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            exs_fwd_q.wr <= 1'b0;
            lsq_fwd_q.wr <= 1'b0;
        end else begin
            exs_fwd_q <= exs_wb_i;
            lsq_fwd_q <= lsq_wb_i;
        end
    end

    assign lsq_fwd_o = lsq_fwd_q;

    // ----------------------------
    // source muxes and operand select
    // ----------------------------
    assign regs1_data_o = fwd_pick(rs1_addr_q_i, rs1_dout_i, exs_wb_i, exs_fwd_q,
                                   lsq_wb_i, lsq_fwd_q);
    assign regs2_data_o = fwd_pick(rs2_addr_q_i, rs2_dout_i, exs_wb_i, exs_fwd_q,
                                   lsq_wb_i, lsq_fwd_q);

    assign operand_left_o  = sels1_pc_q_i  ? pc_q_i  : regs1_data_o;
    assign operand_right_o = sels2_imm_q_i ? imm_q_i : regs2_data_o;

endmodule

// File: rtl/id_stage.sv
// ----------------------------
// instruction decode stage
// accepts fetched words, decodes,
// reads and forwards operands and
// registers the result for execute
// ----------------------------

`include "id_settings.svh"

module id_stage import id_pkg::*; (
    input  logic                      clk_i,
    input  logic                      reset_i,
    // fetch side
    input  logic                      pfu_dav_i,
    input  logic [31:0]               pfu_ins_i,
    input  logic [`RV_XLEN-1:0]       pfu_pc_i,
    output logic                      pfu_ack_o,
    // execute side
    input  logic                      exs_stall_i,
    output logic                      exs_valid_o,
    output exs_out_t                  exs_out_o,
    output logic [`RV_XLEN-1:0]       exs_pc_o,
    output logic [`RV_XLEN-1:0]       exs_operand_left_o,
    output logic [`RV_XLEN-1:0]       exs_operand_right_o,
    output logic [`RV_XLEN-1:0]       exs_regs1_data_o,
    output logic [`RV_XLEN-1:0]       exs_regs2_data_o,
    // write-back
    input  wb_port_t                  exs_wb_i,
    input  wb_port_t                  lsq_wb_i,
    input  logic                      exs_regd_cncl_load_i,
    input  logic [`RV_REG_ADDR_W-1:0] exs_regd_cncl_addr_i
);

    id_ctrl_t                  ctrl;
    logic                      accept;
    logic                      exs_hold;
    logic                      ids_stall;
    wb_port_t                  lsq_fwd;
    logic [`RV_XLEN-1:0]       rs1_dout;
    logic [`RV_XLEN-1:0]       rs2_dout;
    logic [`RV_XLEN-1:0]       imm_q;
    logic                      sels1_pc_q;
    logic                      sels2_imm_q;
    logic [`RV_REG_ADDR_W-1:0] rs1_addr_q;
    logic [`RV_REG_ADDR_W-1:0] rs2_addr_q;

    // execute only holds us while it has something from us
    assign exs_hold  = exs_stall_i & exs_valid_o;
    assign accept    = pfu_dav_i & ~ids_stall & ~exs_hold;
    assign pfu_ack_o = accept;

    ins_decoder u_decoder (
        .ins_i  (pfu_ins_i),
        .ctrl_o (ctrl)
    );

    load_scoreboard u_scoreboard (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .ctrl_i      (ctrl),
        .pfu_dav_i   (pfu_dav_i),
        .accept_i    (accept),
        .lsq_wb_i    (lsq_wb_i),
        .lsq_fwd_i   (lsq_fwd),
        .cncl_i      (exs_regd_cncl_load_i),
        .cncl_addr_i (exs_regd_cncl_addr_i),
        .ids_stall_o (ids_stall)
    );

    int_regs u_regs (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .wa_i       (exs_wb_i),
        .wb_i       (lsq_wb_i),
        .rd_en_i    (accept),
        .rs1_addr_i (ctrl.regs1_addr),
        .rs2_addr_i (ctrl.regs2_addr),
        .rs1_data_o (rs1_dout),
        .rs2_data_o (rs2_dout)
    );

    operand_fwd u_fwd (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .exs_wb_i        (exs_wb_i),
        .lsq_wb_i        (lsq_wb_i),
        .rs1_addr_q_i    (rs1_addr_q),
        .rs2_addr_q_i    (rs2_addr_q),
        .rs1_dout_i      (rs1_dout),
        .rs2_dout_i      (rs2_dout),
        .pc_q_i          (exs_pc_o),
        .imm_q_i         (imm_q),
        .sels1_pc_q_i    (sels1_pc_q),
        .sels2_imm_q_i   (sels2_imm_q),
        .lsq_fwd_o       (lsq_fwd),
        .regs1_data_o    (exs_regs1_data_o),
        .regs2_data_o    (exs_regs2_data_o),
        .operand_left_o  (exs_operand_left_o),
        .operand_right_o (exs_operand_right_o)
    );

    // ----------------------------
    // pipeline register
    // ----------------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            exs_valid_o <= 1'b0;
        end else if (accept) begin
            exs_valid_o <= 1'b1;
        end else if (!exs_hold) begin
            exs_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            exs_out_o <= '{
                ins:       pfu_ins_i,
                alu_op:    ctrl.alu_op,
                funct3:    ctrl.funct3,
                zone:      ctrl.zone,
                regd_addr: ctrl.regd_addr,
                uerr:      ctrl.uerr
            };
            exs_pc_o    <= pfu_pc_i;
            imm_q       <= ctrl.imm;
            sels1_pc_q  <= ctrl.sels1_pc;
            sels2_imm_q <= ctrl.sels2_imm;
            rs1_addr_q  <= ctrl.regs1_addr;
            rs2_addr_q  <= ctrl.regs2_addr;
        end
    end

endmodule

// File: tests/tb_model.svh
// ----------------------------
// reference model for the decode stage
// register mirror and the expected
// execute bundle and operands
// ----------------------------

`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// newest value of each register, live write-backs included
logic [`RV_XLEN-1:0] mirror [`RV_NUM_REGS];

function automatic logic [`RV_XLEN-1:0] read_mirror(input logic [`RV_REG_ADDR_W-1:0] addr);
    return (addr == '0) ? '0 : mirror[addr];
endfunction

// RV32I funct3 table, alt is instruction bit 30
function automatic alu_op_e ref_alu(input logic [2:0] f3, input logic alt);
    case (f3)
        3'd0:    return alt ? SUB : ADD;
        3'd1:    return SLL;
        3'd2:    return SLT;
        3'd3:    return SLTU;
        3'd4:    return XOR;
        3'd5:    return alt ? SRA : SRL;
        3'd6:    return OR;
        default: return AND;
    endcase
endfunction

function automatic void ref_decode(
    input  logic [31:0]         ins,
    input  logic [`RV_XLEN-1:0] pc,
    output exs_out_t            eo,
    output logic [`RV_XLEN-1:0] s1,
    output logic [`RV_XLEN-1:0] s2,
    output logic [`RV_XLEN-1:0] left,
    output logic [`RV_XLEN-1:0] right
);
    logic [2:0]                f3;
    logic [6:0]                f7;
    logic                      ok;
    logic                      shift;
    logic                      use_pc;
    logic                      use_imm;
    logic [`RV_XLEN-1:0]       imm;
    logic [`RV_REG_ADDR_W-1:0] rs1;
    f3      = ins[14:12];
    f7      = ins[31:25];
    rs1     = ins[19:15];
    use_pc  = 1'b0;
    use_imm = 1'b0;
    imm     = '0;
    eo      = '0;
    eo.ins       = ins;
    eo.funct3    = f3;
    eo.regd_addr = ins[11:7];
    eo.alu_op    = ADD;
    eo.zone      = REGF;
    case (ins[6:0])
        `RV_OPC_OP: begin
            ok        = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
            eo.alu_op = ref_alu(f3, ins[30]);
        end
        `RV_OPC_OP_IMM: begin
            shift     = (f3 == 3'd1) || (f3 == 3'd5);
            ok        = !shift || f7 == 7'h00 || (f7 == 7'h20 && f3 == 3'd5);
            eo.alu_op = ref_alu(f3, shift & ins[30]);
            use_imm   = 1'b1;
            imm       = {{20{ins[31]}}, ins[31:20]};
        end
        `RV_OPC_LUI: begin
            ok      = 1'b1;
            rs1     = '0;
            use_imm = 1'b1;
            imm     = {ins[31:12], 12'b0};
        end
        `RV_OPC_AUIPC: begin
            ok      = 1'b1;
            use_pc  = 1'b1;
            use_imm = 1'b1;
            imm     = {ins[31:12], 12'b0};
        end
        `RV_OPC_LOAD: begin
            ok      = (f3 != 3'd3) && (f3 < 3'd6);
            eo.zone = LOADQ;
            use_imm = 1'b1;
            imm     = {{20{ins[31]}}, ins[31:20]};
        end
        default: begin
            ok = 1'b0;
        end
    endcase
    if (!ok) begin
        eo.uerr = 1'b1;
        eo.zone = NONE;
    end
    s1    = read_mirror(rs1);
    s2    = read_mirror(ins[24:20]);
    left  = use_pc ? pc : s1;
    right = use_imm ? imm : s2;
endfunction

`endif

// File: tests/tb_id_stage.sv
// ----------------------------
// decode stage testbench
// LFSR stimulus, register mirror,
// per-cycle compare against the model
// ----------------------------

`include "id_settings.svh"

module tb_id_stage import id_pkg::*; ();

    logic                      clk_i;
    logic                      reset_i;
    logic                      pfu_dav_i;
    logic [31:0]               pfu_ins_i;
    logic [`RV_XLEN-1:0]       pfu_pc_i;
    logic                      pfu_ack_o;
    logic                      exs_stall_i;
    logic                      exs_valid_o;
    exs_out_t                  exs_out_o;
    logic [`RV_XLEN-1:0]       exs_pc_o;
    logic [`RV_XLEN-1:0]       exs_operand_left_o;
    logic [`RV_XLEN-1:0]       exs_operand_right_o;
    logic [`RV_XLEN-1:0]       exs_regs1_data_o;
    logic [`RV_XLEN-1:0]       exs_regs2_data_o;
    wb_port_t                  exs_wb_i;
    wb_port_t                  lsq_wb_i;
    logic                      exs_regd_cncl_load_i;
    logic [`RV_REG_ADDR_W-1:0] exs_regd_cncl_addr_i;

    logic [31:0]               lfsr_q;
    logic [`RV_XLEN-1:0]       pc;

    `include "tb_model.svh"

    id_stage dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // galois LFSR, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v      = {v[30:0], lfsr_q[0]};
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'hA300_0000) : (lfsr_q >> 1);
        end
        return v;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    task automatic fail_timeout(input string what);
        $display("timeout at %0t: %s", $time, what);
        $display("Errors found");
        $fatal(1);
    endtask

    // random OP or OP-IMM word with a legal funct7
    function automatic logic [31:0] gen_alu(input logic use_imm);
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [2:0]  f3;
        logic [11:0] imm;
        rd  = 5'(take_bits(5));
        rs1 = 5'(take_bits(5));
        f3  = 3'(take_bits(3));
        imm = 12'(take_bits(12));
        if (f3 == 3'd1) begin
            imm[11:5] = 7'h00;
        end
        if (f3 == 3'd5 || (f3 == 3'd0 && !use_imm)) begin
            imm[11:5] = take_bits(1) ? 7'h20 : 7'h00;
        end
        if (!use_imm && f3 != 3'd0 && f3 != 3'd5) begin
            imm[11:5] = 7'h00;
        end
        return {imm, rs1, f3, rd, use_imm ? `RV_OPC_OP_IMM : `RV_OPC_OP};
    endfunction

    task automatic set_wb(input logic lsq, input logic [4:0] addr, input logic [31:0] data);
        if (lsq) begin
            lsq_wb_i = '{wr: 1'b1, addr: addr, data: data};
        end else begin
            exs_wb_i = '{wr: 1'b1, addr: addr, data: data};
        end
        mirror[addr] = data;
    endtask

    task automatic clear_wb();
        exs_wb_i = '0;
        lsq_wb_i = '0;
    endtask

    // hold the word until accepted, return at the next falling edge
    task automatic send_ins(input logic [31:0] ins);
        int waited;
        pfu_dav_i = 1'b1;
        pfu_ins_i = ins;
        pfu_pc_i  = pc;
        waited    = 0;
        #1;
        while (!pfu_ack_o) begin
            @(negedge clk_i);
            #1;
            waited++;
            if (waited > 50) begin
                fail_timeout("fetch word was never accepted");
            end
        end
        @(negedge clk_i);
        pfu_dav_i = 1'b0;
        pc        = pc + 4;
    endtask

    // compare just before each rising edge
    initial begin : compare
        logic [31:0]         cur_ins;
        logic [`RV_XLEN-1:0] cur_pc;
        logic                exp_valid;
        exs_out_t            eo;
        logic [`RV_XLEN-1:0] s1;
        logic [`RV_XLEN-1:0] s2;
        logic [`RV_XLEN-1:0] left;
        logic [`RV_XLEN-1:0] right;
        exp_valid = 1'b0;
        forever begin
            @(negedge clk_i);
            #4;
            if (reset_i) begin
                exp_valid = 1'b0;
            end else begin
                check_val("exs_valid_o", 32'(exs_valid_o), 32'(exp_valid));
                if (exp_valid && !exs_stall_i) begin
                    ref_decode(cur_ins, cur_pc, eo, s1, s2, left, right);
                    check_val("exs_out_o.ins", exs_out_o.ins, eo.ins);
                    check_val("exs_out_o.uerr", 32'(exs_out_o.uerr), 32'(eo.uerr));
                    check_val("exs_out_o.zone", 32'(exs_out_o.zone), 32'(eo.zone));
                    check_val("exs_out_o.funct3", 32'(exs_out_o.funct3), 32'(eo.funct3));
                    check_val("exs_out_o.regd_addr", 32'(exs_out_o.regd_addr),
                              32'(eo.regd_addr));
                    if (!eo.uerr) begin
                        check_val("exs_out_o.alu_op", 32'(exs_out_o.alu_op),
                                  32'(eo.alu_op));
                    end
                    check_val("exs_pc_o", exs_pc_o, cur_pc);
                    check_val("exs_regs1_data_o", exs_regs1_data_o, s1);
                    check_val("exs_regs2_data_o", exs_regs2_data_o, s2);
                    check_val("exs_operand_left_o", exs_operand_left_o, left);
                    check_val("exs_operand_right_o", exs_operand_right_o, right);
                end
                // valid stays up while execute holds it
                if (pfu_ack_o) begin
                    cur_ins   = pfu_ins_i;
                    cur_pc    = pfu_pc_i;
                    exp_valid = 1'b1;
                end else if (!exs_stall_i) begin
                    exp_valid = 1'b0;
                end
            end
        end
    end

    initial begin : stimulus
        exs_out_t            snap_out;
        logic [`RV_XLEN-1:0] snap_pc;
        logic [`RV_XLEN-1:0] snap_left;
        logic [`RV_XLEN-1:0] snap_right;
        lfsr_q               = 32'd87270;
        pc                   = 32'h0000_1000;
        reset_i              = 1'b1;
        pfu_dav_i            = 1'b0;
        pfu_ins_i            = '0;
        pfu_pc_i             = '0;
        exs_stall_i          = 1'b0;
        exs_wb_i             = '0;
        lsq_wb_i             = '0;
        exs_regd_cncl_load_i = 1'b0;
        exs_regd_cncl_addr_i = '0;
        for (int r = 0; r < `RV_NUM_REGS; r++) begin
            mirror[r] = '0;
        end
        repeat (2) @(negedge clk_i);
        reset_i = 1'b0;
        #1;
        check_val("exs_valid_o", 32'(exs_valid_o), 32'd0);
        check_val("pfu_ack_o", 32'(pfu_ack_o), 32'd0);
        @(negedge clk_i);

        // ------------------------------
        // preload, then random ALU words
        // ------------------------------
        for (int r = 1; r < `RV_NUM_REGS; r++) begin
            set_wb(1'b0, r[4:0], take_bits(32));
            @(negedge clk_i);
        end
        clear_wb();
        for (int n = 0; n < 40; n++) begin
            send_ins(gen_alu(1'(take_bits(1))));
        end
        // upper immediates
        for (int n = 0; n < 8; n++) begin
            send_ins({20'(take_bits(20)), 5'(take_bits(5)),
                      n[0] ? `RV_OPC_AUIPC : `RV_OPC_LUI});
        end
        // unsupported words
        send_ins({7'h01, 5'd3, 5'd4, 3'd0, 5'd5, `RV_OPC_OP});
        send_ins({7'h20, 5'd3, 5'd4, 3'd4, 5'd5, `RV_OPC_OP});
        send_ins({25'(take_bits(25)), 7'b1101111});
        send_ins({25'(take_bits(25)), 7'b0100011});
        @(negedge clk_i);

        // ------------------------------
        // load to x9, then a reader of x9
        // ------------------------------
        send_ins({12'h010, 5'd2, 3'd2, 5'd9, `RV_OPC_LOAD});
        fork
            send_ins({7'h00, 5'd9, 5'd3, 3'd0, 5'd4, `RV_OPC_OP});
            begin
                repeat (3) begin
                    #1;
                    check_val("pfu_ack_o", 32'(pfu_ack_o), 32'd0);
                    @(negedge clk_i);
                end
                set_wb(1'b1, 5'd9, take_bits(32));
                @(negedge clk_i);
                clear_wb();
            end
        join
        @(negedge clk_i);

        // write-back in the accept cycle, on each port
        set_wb(1'b0, 5'd12, take_bits(32));
        send_ins({7'h00, 5'd13, 5'd12, 3'd0, 5'd6, `RV_OPC_OP});
        clear_wb();
        @(negedge clk_i);
        set_wb(1'b1, 5'd13, take_bits(32));
        send_ins({7'h00, 5'd12, 5'd13, 3'd4, 5'd6, `RV_OPC_OP});
        clear_wb();
        @(negedge clk_i);

        // accept-cycle write, then a write while execute holds the stage
        set_wb(1'b0, 5'd14, take_bits(32));
        send_ins({7'h00, 5'd15, 5'd14, 3'd6, 5'd7, `RV_OPC_OP});
        clear_wb();
        exs_stall_i = 1'b1;
        set_wb(1'b1, 5'd15, take_bits(32));
        @(negedge clk_i);
        clear_wb();
        @(negedge clk_i);
        @(negedge clk_i);
        exs_stall_i = 1'b0;
        @(negedge clk_i);

        // ------------------------------
        // stall holds outputs and ack
        // ------------------------------
        send_ins(gen_alu(1'b1));
        exs_stall_i = 1'b1;
        snap_out   = exs_out_o;
        snap_pc    = exs_pc_o;
        snap_left  = exs_operand_left_o;
        snap_right = exs_operand_right_o;
        fork
            send_ins(gen_alu(1'b0));
            begin
                repeat (3) begin
                    @(negedge clk_i);
                    #1;
                    check_val("pfu_ack_o", 32'(pfu_ack_o), 32'd0);
                    check_val("exs_out_o.ins", exs_out_o.ins, snap_out.ins);
                    check_val("exs_pc_o", exs_pc_o, snap_pc);
                    check_val("exs_operand_left_o", exs_operand_left_o, snap_left);
                    check_val("exs_operand_right_o", exs_operand_right_o, snap_right);
                end
                @(negedge clk_i);
                exs_stall_i = 1'b0;
            end
        join
        repeat (3) @(negedge clk_i);

        $display("No errors");
        $finish;
    end

endmodule

// File: files.f
+incdir+rtl
+incdir+tests
rtl/id_pkg.sv
rtl/ins_decoder.sv
rtl/load_scoreboard.sv
rtl/int_regs.sv
rtl/operand_fwd.sv
rtl/id_stage.sv
tests/tb_id_stage.sv

// File: Makefile
# Verilator build and run for the decode stage testbench

VERILATOR ?= verilator
TOP       ?= tb_id_stage
RTL_TOP   ?= id_stage
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
LINTFLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "No errors" $(LOG) || (echo "simulation failed" && exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
